//--- cgra_lite.f
design/cgra_pkg.sv
design/cgra_instr_store.sv
design/cgra_column.sv
design/cgra_frame_tracker.sv
design/cgra_lite_top.sv
dv/cgra_lite_checker.sv
dv/cgra_lite_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cgra_lite testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cgra_lite_tb -f cgra_lite.f -Mdir obj_dir -o cgra_lite_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/cgra_lite_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/cgra_lite_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_lite_tb;
    import cgra_pkg::*;

    localparam int NUM_COL         = DEF_NUM_COL;
    localparam int DEPTH           = DEF_DEPTH;
    localparam int TOTAL_FRAMES    = 41;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 12 * 200 + 2000;

    logic        ap_clk;
    logic        rst;
    cfg_t        cfg;
    logic        cfg_valid;
    logic        cfg_ready;
    beat_t       in_beat;
    logic        in_valid;
    logic        in_ready;
    beat_t       out_beat;
    logic        out_valid;
    logic        out_ready;
    logic        done;
    logic [31:0] frame_cycles;

    // reference model state per column
    instr_t      m_instr [NUM_COL][DEPTH];
    int          m_len [NUM_COL];
    int          m_pc [NUM_COL];
    beat_t       exp_q [$];
    logic [31:0] cyc_q [$];

    logic [31:0] stim_state = 32'haeea;
    logic [31:0] bp_state = ~32'haeea;
    logic        bp_on = 1'b0;
    logic        gaps_on = 1'b0;
    logic        tb_frame_active = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          n_tests = 0;
    int          frames_sent = 0;
    int          done_count = 0;
    int          edge_no = 0;
    int          start_edge = 0;
    string       cur_test = "reset";

    cgra_lite_top #(
        .NUM_COL (NUM_COL),
        .DEPTH   (DEPTH)
    ) dut (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .done         (done),
        .frame_cycles (frame_cycles)
    );

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'(r[31:8] % 24'(hi - lo + 1));
    endfunction

    // opcode rules with imm zero extended and results modulo 2^32
    function automatic logic [31:0] apply_op(input instr_t ins, input logic [31:0] d);
        logic [31:0] imm32;
        imm32 = {16'd0, ins.imm};
        case (ins.op)
            OP_ADD:  return d + imm32;
            OP_SUB:  return d - imm32;
            OP_XOR:  return d ^ imm32;
            OP_MUL:  return d * imm32;
            OP_SHL:  return d << ins.imm[4:0];
            default: return d;
        endcase
    endfunction

    function automatic cfg_t make_instr(input int col, input int addr, input op_e op,
                                        input logic [15:0] imm);
        cfg_t c;
        c.kind      = CFG_INSTR;
        c.col       = 4'(col);
        c.addr      = 8'(addr);
        c.instr.op  = op;
        c.instr.imm = imm;
        return c;
    endfunction

    function automatic cfg_t make_len(input int col, input int len);
        cfg_t c;
        c.kind  = CFG_LEN;
        c.col   = 4'(col);
        c.addr  = 8'(len);
        c.instr = '0;
        return c;
    endfunction

    task automatic model_cfg(input cfg_t c);
        int col_i;
        int addr_i;
        col_i  = int'(c.col);
        addr_i = int'(c.addr);
        if (col_i < NUM_COL) begin
            if (c.kind == CFG_INSTR && addr_i < DEPTH) begin
                m_instr[col_i][addr_i] = c.instr;
            end else if (c.kind == CFG_LEN && addr_i != 0 && addr_i <= DEPTH) begin
                m_len[col_i] = addr_i;
            end
        end
    endtask

    // word runs through every column and steps each program counter once
    task automatic model_accept(input beat_t b);
        beat_t e;
        e = b;
        for (int c = 0; c < NUM_COL; c++) begin
            e.data = apply_op(m_instr[c][m_pc[c]], e.data);
            if (b.last || m_pc[c] + 1 >= m_len[c]) begin
                m_pc[c] = 0;
            end else begin
                m_pc[c] = m_pc[c] + 1;
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic check_beat(input string name, input beat_t exp_b, input beat_t act_b);
        checks++;
        if (exp_b !== act_b) begin
            errors++;
            $display("Mismatch in %s: expected data %08h last %0b, actual data %08h last %0b",
                     name, exp_b.data, exp_b.last, act_b.data, act_b.last);
        end
    endtask

    task automatic check_cycles(input string name, input logic [31:0] exp_c,
                                input logic [31:0] act_c);
        checks++;
        if (exp_c !== act_c) begin
            errors++;
            $display("Mismatch in %s: expected frame_cycles %0d, actual %0d",
                     name, exp_c, act_c);
        end
    endtask

    task automatic cfg_write(input cfg_t c, output int waited);
        cfg       = c;
        cfg_valid = 1'b1;
        waited    = 0;
        @(negedge ap_clk);
        while (!cfg_ready) begin
            waited++;
            @(negedge ap_clk);
        end
        if (tb_frame_active) begin
            errors++;
            $display("%s: configuration was accepted while a frame was active", cur_test);
        end
        model_cfg(c);
        @(posedge ap_clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic program_columns();
        int waited;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int a = 0; a < DEPTH; a++) begin
                cfg_write(make_instr(c, a, op_e'(3'(rand_range(0, 5))), 16'(next_rand())),
                          waited);
            end
            cfg_write(make_len(c, rand_range(1, DEPTH)), waited);
        end
    endtask

    task automatic send_frame(input int n_words);
        beat_t b;
        for (int i = 0; i < n_words; i++) begin
            if (gaps_on && rand_range(0, 3) == 0) begin
                in_valid = 1'b0;
                repeat (rand_range(1, 3)) @(posedge ap_clk);
                #2;
            end
            b.data   = next_rand();
            b.last   = (i == n_words - 1);
            in_beat  = b;
            in_valid = 1'b1;
            @(negedge ap_clk);
            while (!in_ready) @(negedge ap_clk);
            @(posedge ap_clk);
            model_accept(b);
            #2;
        end
        in_valid = 1'b0;
        frames_sent++;
        while (done_count < frames_sent) @(posedge ap_clk);
        #2;
    endtask

    task automatic end_test(input int err_before);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected output words never arrived", cur_test, exp_q.size());
            exp_q.delete();
        end
        if (done_count != frames_sent) begin
            errors++;
            $display("%s: saw %0d done pulses for %0d frames", cur_test, done_count, frames_sent);
        end
        n_tests++;
        if (errors == err_before) begin
            $display("PASS %s", cur_test);
        end else begin
            $display("FAIL %s with %0d errors", cur_test, errors - err_before);
        end
    endtask

    // random back-pressure on the output stream
    always @(posedge ap_clk) begin
        #2;
        bp_state  = lcg_next(bp_state);
        out_ready = !bp_on || (bp_state[29:28] != 2'b00);
    end

    // handshakes sampled mid-cycle and the transfer lands on the next edge
    always @(negedge ap_clk) begin
        beat_t exp_b;
        edge_no++;
        if (!rst) begin
            if (in_valid && in_ready && !tb_frame_active) begin
                tb_frame_active = 1'b1;
                start_edge      = edge_no;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: output word arrived with no input word to match", cur_test);
                end else begin
                    exp_b = exp_q.pop_front();
                    check_beat(cur_test, exp_b, out_beat);
                end
                if (out_beat.last) begin
                    cyc_q.push_back(32'(edge_no - start_edge + 1));
                    tb_frame_active = 1'b0;
                end
            end
            if (done) begin
                done_count++;
                if (cyc_q.size() == 0) begin
                    errors++;
                    $display("%s: done pulsed with no finished frame", cur_test);
                end else begin
                    check_cycles(cur_test, cyc_q.pop_front(), frame_cycles);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int err0;
        int waited;
        rst       = 1'b1;
        cfg       = '0;
        cfg_valid = 1'b0;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int a = 0; a < DEPTH; a++) begin
                m_instr[c][a] = '0;
            end
            m_len[c] = 1;
            m_pc[c]  = 0;
        end
        repeat (3) @(posedge ap_clk);
        #2;
        rst = 1'b0;

        cur_test = "pass_after_reset";
        err0     = errors;
        for (int f = 0; f < 4; f++) begin
            send_frame(rand_range(1, 12));
        end
        end_test(err0);

        // column 0 walks through every opcode
        cur_test = "single_instr_opcodes";
        err0     = errors;
        for (int f = 0; f < 12; f++) begin
            for (int c = 0; c < NUM_COL; c++) begin
                cfg_write(make_instr(c, 0, op_e'(3'(c == 0 ? f % 6 : rand_range(0, 5))),
                                     16'(next_rand())), waited);
                cfg_write(make_len(c, 1), waited);
            end
            send_frame(rand_range(1, 12));
        end
        end_test(err0);

        // two frames per program so the second starts again at slot 0
        cur_test = "program_wrap";
        err0     = errors;
        for (int p = 0; p < 4; p++) begin
            program_columns();
            send_frame(rand_range(1, 12));
            send_frame(rand_range(1, 12));
        end
        end_test(err0);

        cur_test = "backpressure_gaps";
        err0     = errors;
        bp_on    = 1'b1;
        gaps_on  = 1'b1;
        for (int f = 0; f < 10; f++) begin
            send_frame(rand_range(1, 12));
        end
        end_test(err0);

        cur_test  = "done_and_cycles";
        err0      = errors;
        bp_on     = 1'b0;
        gaps_on   = 1'b0;
        out_ready = 1'b1;
        send_frame(1);
        check_cycles("single word frame_cycles", 32'(NUM_COL + 1), frame_cycles);
        bp_on   = 1'b1;
        gaps_on = 1'b1;
        for (int f = 0; f < 4; f++) begin
            send_frame(rand_range(1, 12));
        end
        end_test(err0);

        cur_test = "cfg_mid_frame";
        err0     = errors;
        // two distinct slots in the last column so a taken zero length would show
        cfg_write(make_instr(NUM_COL - 1, 0, OP_PASS, 16'h0000), waited);
        cfg_write(make_instr(NUM_COL - 1, 1, OP_ADD, 16'h0001), waited);
        cfg_write(make_len(NUM_COL - 1, 2), waited);
        fork
            send_frame(8);
            begin
                wait (tb_frame_active);
                @(posedge ap_clk);
                #2;
                cfg_write(make_instr(0, 0, OP_XOR, 16'h5a5a), waited);
                if (waited == 0) begin
                    errors++;
                    $display("%s: cfg_ready was not held low during the frame", cur_test);
                end
                cfg_write(make_len(NUM_COL - 1, 0), waited);
                cfg_write(make_len(0, DEPTH + 3), waited);
            end
        join
        send_frame(6);
        end_test(err0);

        errors += int'(dut.u_checker.fail_count);
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cgra_lite_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_lite_checker (
    input wire logic            ap_clk,
    input wire logic            rst,
    input wire cgra_pkg::beat_t out_beat,
    input wire logic            out_valid,
    input wire logic            out_ready,
    input wire logic            done,
    input wire logic            cfg_ready
);

    int unsigned fail_count = 0;

    // stalled output word is held until taken
    out_hold: assert property (@(posedge ap_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("out_beat or out_valid changed while stalled");
            fail_count++;
        end

    done_single: assert property (@(posedge ap_clk) disable iff (rst)
        done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // a word at the output means a frame is still open
    cfg_closed: assert property (@(posedge ap_clk) disable iff (rst)
        out_valid |-> !cfg_ready)
        else begin
            $error("cfg_ready high while an output word is pending");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge ap_clk)
        rst |=> !out_valid)
        else begin
            $error("out_valid high after a reset cycle");
            fail_count++;
        end

endmodule

bind cgra_lite_top cgra_lite_checker u_checker (
    .ap_clk    (ap_clk),
    .rst       (rst),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .done      (done),
    .cfg_ready (cfg_ready)
);

`default_nettype wire

//--- design/cgra_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_lite_top #(
    parameter int NUM_COL = cgra_pkg::DEF_NUM_COL,
    parameter int DEPTH   = cgra_pkg::DEF_DEPTH
) (
    input  wire logic             ap_clk,
    input  wire logic             rst,
    input  wire cgra_pkg::cfg_t   cfg,
    input  wire logic             cfg_valid,
    output logic                  cfg_ready,
    input  wire cgra_pkg::beat_t  in_beat,
    input  wire logic             in_valid,
    output logic                  in_ready,
    output cgra_pkg::beat_t       out_beat,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output logic                  done,
    output logic [31:0]           frame_cycles
);
    import cgra_pkg::*;

    // index k is the input of column k, index NUM_COL the output stream
    beat_t            stage_beat [NUM_COL+1];
    logic [NUM_COL:0] stage_valid;
    logic [NUM_COL:0] stage_ready;

    assign stage_beat[0]        = in_beat;
    assign out_beat             = stage_beat[NUM_COL];
    assign out_valid            = stage_valid[NUM_COL];
    assign stage_ready[NUM_COL] = out_ready;

    cgra_frame_tracker u_tracker (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_last      (in_beat.last),
        .col_ready    (stage_ready[0]),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_beat.last),
        .in_ready     (in_ready),
        .col_valid    (stage_valid[0]),
        .cfg_ready    (cfg_ready),
        .done         (done),
        .frame_cycles (frame_cycles)
    );

    // column chain, config is broadcast and each column picks its own index
    for (genvar k = 0; k < NUM_COL; k++) begin : g_col
        cgra_column #(
            .DEPTH     (DEPTH),
            .COL_INDEX (k)
        ) u_col (
            .ap_clk    (ap_clk),
            .rst       (rst),
            .cfg       (cfg),
            .cfg_valid (cfg_valid),
            .cfg_ready (cfg_ready),
            .in_beat   (stage_beat[k]),
            .in_valid  (stage_valid[k]),
            .in_ready  (stage_ready[k]),
            .out_beat  (stage_beat[k+1]),
            .out_valid (stage_valid[k+1]),
            .out_ready (stage_ready[k+1])
        );
    end

endmodule

`default_nettype wire

//--- design/cgra_frame_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_frame_tracker (
    input  wire logic  ap_clk,
    input  wire logic  rst,
    input  wire logic  in_valid,
    input  wire logic  in_last,
    input  wire logic  col_ready,
    input  wire logic  out_valid,
    input  wire logic  out_ready,
    input  wire logic  out_last,
    output logic       in_ready,
    output logic       col_valid,
    output logic       cfg_ready,
    output logic       done,
    output logic [31:0] frame_cycles
);

    logic        active;
    logic        last_in;
    logic [31:0] cycle_cnt;
    logic        in_fire;
    logic        out_fire;
    logic        frame_end;

    // input gate shut once the last word of the frame is inside
    assign in_ready  = col_ready && !last_in;
    assign col_valid = in_valid && !last_in;

    assign in_fire   = in_valid && in_ready;
    assign out_fire  = out_valid && out_ready;
    assign frame_end = out_fire && out_last;

    // an offered word also holds off config, so a write never lands
    // on the same edge as the first accept of a frame
    assign cfg_ready = !active && !in_valid;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            active  <= 1'b0;
            last_in <= 1'b0;
        end else begin
            if (frame_end) begin
                active <= 1'b0;
            end else if (in_fire) begin
                active <= 1'b1;
            end

            if (frame_end) begin
                last_in <= 1'b0;
            end else if (in_fire && in_last) begin
                last_in <= 1'b1;
            end
        end
    end

    // first accept edge counts as 1
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else if (in_fire && !active) begin
            cycle_cnt <= 32'd1;
        end else if (active) begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // count includes the final output edge itself
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            frame_cycles <= '0;
            done         <= 1'b0;
        end else begin
            done <= frame_end;
            if (frame_end) begin
                frame_cycles <= cycle_cnt + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cgra_column.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_column #(
    parameter int DEPTH     = cgra_pkg::DEF_DEPTH,
    parameter int COL_INDEX = 0
) (
    input  wire logic             ap_clk,
    input  wire logic             rst,
    input  wire cgra_pkg::cfg_t   cfg,
    input  wire logic             cfg_valid,
    input  wire logic             cfg_ready,
    input  wire cgra_pkg::beat_t  in_beat,
    input  wire logic             in_valid,
    output logic                  in_ready,
    output cgra_pkg::beat_t       out_beat,
    output logic                  out_valid,
    input  wire logic             out_ready
);
    import cgra_pkg::*;

    instr_t            instr;
    logic              in_fire;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] result;

    // room when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    assign imm_ext = DATA_W'(instr.imm);

    cgra_instr_store #(
        .DEPTH     (DEPTH),
        .COL_INDEX (COL_INDEX)
    ) u_store (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .advance      (in_fire),
        .advance_last (in_beat.last),
        .instr        (instr)
    );

    // execute, all results wrap at 32 bits
    always_comb begin
        case (instr.op)
            OP_PASS: begin
                result = in_beat.data;
            end
            OP_ADD: begin
                result = in_beat.data + imm_ext;
            end
            OP_SUB: begin
                result = in_beat.data - imm_ext;
            end
            OP_XOR: begin
                result = in_beat.data ^ imm_ext;
            end
            OP_MUL: begin
                // low half of the product only
                result = in_beat.data * imm_ext;
            end
            OP_SHL: begin
                result = in_beat.data << imm_ext[4:0];
            end
            default: begin
                result = in_beat.data;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // stage register, last flag passes untouched
    always_ff @(posedge ap_clk) begin
        if (in_fire) begin
            out_beat <= '{data: result, last: in_beat.last};
        end
    end

endmodule

`default_nettype wire

//--- design/cgra_instr_store.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_instr_store #(
    parameter int DEPTH     = cgra_pkg::DEF_DEPTH,
    parameter int COL_INDEX = 0
) (
    input  wire logic             ap_clk,
    input  wire logic             rst,
    input  wire cgra_pkg::cfg_t   cfg,
    input  wire logic             cfg_valid,
    input  wire logic             cfg_ready,
    input  wire logic             advance,
    input  wire logic             advance_last,
    output cgra_pkg::instr_t      instr
);
    import cgra_pkg::*;

    localparam int PC_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LEN_W = $clog2(DEPTH + 1);

    instr_t           mem [DEPTH];
    logic [PC_W-1:0]  pc;
    logic [LEN_W-1:0] len;
    logic             cfg_hit;
    logic             pc_wrap;

    // only transfers addressed to this column
    assign cfg_hit = cfg_valid && cfg_ready && (cfg.col == 4'(COL_INDEX));

    // last slot of the program reached
    assign pc_wrap = (LEN_W'(pc) + LEN_W'(1)) >= len;

    // program memory and length, both start as a single pass instruction
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '{op: OP_PASS, imm: '0};
            end
            len <= LEN_W'(1);
        end else if (cfg_hit) begin
            if (cfg.kind == CFG_INSTR) begin
                if (cfg.addr < DEPTH) begin
                    mem[cfg.addr[PC_W-1:0]] <= cfg.instr;
                end
            end else begin
                // zero or oversized lengths are dropped
                if (cfg.addr != 8'd0 && cfg.addr <= DEPTH) begin
                    len <= cfg.addr[LEN_W-1:0];
                end
            end
        end
    end

    // one step per accepted word, back to slot 0 at frame end
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            pc <= '0;
        end else if (advance) begin
            if (advance_last || pc_wrap) begin
                pc <= '0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    assign instr = mem[pc];

endmodule

`default_nettype wire

//--- design/cgra_pkg.sv
`default_nettype none

package cgra_pkg;

    // stream and immediate widths
    parameter int DATA_W = 32;
    parameter int IMM_W  = 16;

    // defaults for the top level parameters
    parameter int DEF_NUM_COL = 2;
    parameter int DEF_DEPTH   = 8;

    // column opcodes, codes 6 and 7 behave as pass
    typedef enum logic [2:0] {
        OP_PASS = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_XOR  = 3'd3,
        OP_MUL  = 3'd4,
        OP_SHL  = 3'd5
    } op_e;

    typedef struct packed {
        op_e              op;
        logic [IMM_W-1:0] imm;
    } instr_t;

    typedef enum logic {
        CFG_INSTR = 1'b0,
        CFG_LEN   = 1'b1
    } cfg_kind_e;

    // for CFG_LEN the program length rides in addr
    typedef struct packed {
        cfg_kind_e  kind;
        logic [3:0] col;
        logic [7:0] addr;
        instr_t     instr;
    } cfg_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } beat_t;

endpackage

`default_nettype wire
